/* tb.f */
pm_pkg.sv
req_regs.sv
img_delay_ctl.sv
pm_ctl.sv
motor_gen.sv
pm_channel.sv
status_collect.sv
pm_top.sv
tb_clk.sv
pm_props.sv
tb_pm.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module tb_pm -o sim_tb_pm || exit 1
./obj_dir/sim_tb_pm | tee /dev/stderr | grep -q "TEST RESULT: PASS" && exit 0 || exit 1

/* tb_pm.sv */
module tb_pm;

	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic resetn;
	logic wr_en;
	pm_pkg::ch_t wr_ch;
	pm_pkg::pm_req_t wr_req;
	logic go;
	pm_pkg::axis_mask_t go_mask;
	logic img_pulse;
	pm_pkg::axis_mask_t img_valid;
	pm_pkg::px_t [pm_pkg::n_axis-1:0] img_pos;
	pm_pkg::step_t [pm_pkg::n_axis-1:0] position;
	pm_pkg::axis_mask_t done_mask;
	pm_pkg::axis_mask_t over_mask;
	logic all_done;

	integer seed = 18258;
	// model state per axis
	pm_pkg::step_t exp_pos [pm_pkg::n_axis];
	pm_pkg::axis_mask_t exp_over;
	pm_pkg::px_t pix [pm_pkg::n_axis];

	tb_clk u_clk (
		.clk    (clk),
		.resetn (resetn)
	);

	pm_top DUT (
		.clk       (clk),
		.resetn    (resetn),
		.wr_en     (wr_en),
		.wr_ch     (wr_ch),
		.wr_req    (wr_req),
		.go        (go),
		.go_mask   (go_mask),
		.img_pulse (img_pulse),
		.img_valid (img_valid),
		.img_pos   (img_pos),
		.position  (position),
		.done_mask (done_mask),
		.over_mask (over_mask),
		.all_done  (all_done)
	);

	bind pm_ctl pm_props u_props (
		.clk       (clk),
		.resetn    (resetn),
		.arm       (arm),
		.img_pulse (img_pulse),
		.dep_img   (req.dep_img),
		.pen_d5    (pen_d5),
		.m_start   (m_start)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_val(input string name, input string what, input int exp, input int act);
		assert (exp == act)
		else abort_run($sformatf("Error %s %s expected %0d actual %0d", name, what, exp, act));
	endtask

	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return lo + r % (hi - lo + 1);
	endfunction

	// steps per pixel for each 512 pixel band of error
	function automatic int band_gain(input int err);
		case (err >> 9)
			0, 1: return 1;
			2, 3: return 2;
			4, 5: return 3;
			default: return 4;
		endcase
	endfunction

	task automatic write_req(input int ch, input pm_pkg::pm_req_t r);
		@(posedge clk);
		wr_en <= 1'b1;
		wr_ch <= pm_pkg::ch_t'(ch);
		wr_req <= r;
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	task automatic fire(input pm_pkg::axis_mask_t mask);
		@(posedge clk);
		go <= 1'b1;
		go_mask <= mask;
		@(posedge clk);
		go <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic frame();
		@(posedge clk);
		img_pulse <= 1'b1;
		@(posedge clk);
		img_pulse <= 1'b0;
		repeat (8) @(posedge clk);
	endtask

	task automatic wait_all_done(input string name);
		int n = 0;
		@(negedge clk);
		while (!all_done && n < 200000) begin
			@(negedge clk);
			n++;
		end
		assert (all_done)
		else abort_run($sformatf("%s timed out waiting for all axes to finish", name));
	endtask

	// kind 0 relative, 1 absolute, 2 in window, 3 allowed move, 4 against allowed side
	task automatic plan_axis(input int i, input int kind);
		pm_pkg::pm_req_t r;
		int dst;
		int tol;
		int px;
		int err;
		int mv;
		r = '0;
		r.speed = pm_pkg::speed_t'(rand_range(0, 2));
		r.delay_frm = pm_pkg::frm_t'(rand_range(0, 3));
		dst = rand_range(64, 4031);
		tol = rand_range(0, 63);
		r.img_dst = pm_pkg::px_t'(dst);
		r.img_tol = pm_pkg::px_t'(tol);
		exp_over[i] = 1'b0;
		if (kind < 2) begin
			r.abs = kind == 1;
			r.step = pm_pkg::step_t'(rand_range(-300, 300));
			exp_pos[i] = r.abs ? r.step : exp_pos[i] + r.step;
		end else begin
			r.dep_img = 1'b1;
			if (kind == 2)
				px = dst + rand_range(-tol, tol);
			else if (rand_range(0, 1) == 1)
				px = rand_range(dst + tol + 1, 4095);
			else
				px = rand_range(0, dst - tol - 1);
			err = px > dst ? px - dst : dst - px;
			mv = band_gain(err) * err;
			// pixel past target means stepping back when l2r is set
			if ((px > dst) == pm_pkg::l2r)
				mv = -mv;
			if (kind == 2) begin
				r.step = pm_pkg::step_t'(rand_range(0, 1) == 1 ? 1 : -1);
			end else if (kind == 3) begin
				r.step = pm_pkg::step_t'(mv < 0 ? -1 : 1);
				exp_pos[i] = exp_pos[i] + mv;
			end else begin
				r.step = pm_pkg::step_t'(mv < 0 ? 1 : -1);
				exp_over[i] = 1'b1;
			end
			pix[i] = pm_pkg::px_t'(px);
		end
		write_req(i, r);
	endtask

	task automatic check_axes(input string name, input pm_pkg::axis_mask_t mask);
		@(negedge clk);
		for (int i = 0; i < pm_pkg::n_axis; i++) begin
			check_val(name, $sformatf("axis %0d position", i), exp_pos[i], position[i]);
			if (mask[i]) begin
				check_val(name, $sformatf("axis %0d done", i), 1, int'(done_mask[i]));
				check_val(name, $sformatf("axis %0d over", i), int'(exp_over[i]),
					int'(over_mask[i]));
			end
		end
	endtask

	// negative kind picks a random behavior per axis
	task automatic run_round(input string name, input pm_pkg::axis_mask_t mask, input int kind);
		// settle the frame history on the idle positions
		repeat (4) frame();
		for (int i = 0; i < pm_pkg::n_axis; i++) begin
			if (mask[i])
				plan_axis(i, kind < 0 ? rand_range(0, 4) : kind);
		end
		@(posedge clk);
		for (int i = 0; i < pm_pkg::n_axis; i++)
			img_pos[i] <= pix[i];
		fire(mask);
		frame();
		wait_all_done(name);
		check_axes(name, mask);
	endtask

	initial begin
		pm_pkg::axis_mask_t mask;
		wr_en = 1'b0;
		wr_ch = '0;
		wr_req = '0;
		go = 1'b0;
		go_mask = '0;
		img_pulse = 1'b0;
		img_valid = '1;
		img_pos = '0;
		exp_over = '0;
		for (int i = 0; i < pm_pkg::n_axis; i++) begin
			exp_pos[i] = '0;
			pix[i] = '0;
		end
		repeat (8) @(posedge clk);

		run_round("direct_rel", '1, 0);
		run_round("direct_abs", '1, 1);
		run_round("img_in_window", '1, 2);
		run_round("img_move", '1, 3);
		run_round("img_against", '1, 4);
		for (int t = 0; t < 8; t++) begin
			mask = pm_pkg::axis_mask_t'(rand_range(1, (1 << pm_pkg::n_axis) - 1));
			run_round($sformatf("mixed_%0d", t), mask, -1);
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* pm_props.sv */
module pm_props (
	input logic clk,
	input logic resetn,
	input logic arm,
	input logic img_pulse,
	input logic dep_img,
	input logic pen_d5,
	input logic m_start
);

	timeunit 1ns;
	timeprecision 1ps;

	// an arm that has not yet been answered by a start
	logic arm_open;

	always_ff @(posedge clk) begin
		if (!resetn)
			arm_open <= 1'b0;
		else if (arm)
			arm_open <= 1'b1;
		else if (m_start)
			arm_open <= 1'b0;
	end

	start_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
		m_start |=> !m_start)
		else $error("m_start stayed high for more than one cycle");

	start_after_arm: assert property (@(posedge clk) disable iff (!resetn)
		m_start |-> arm_open)
		else $error("m_start without a preceding arm");

	// image pipeline is exactly five stages deep
	pipe_depth: assert property (@(posedge clk) disable iff (!resetn)
		pen_d5 == $past(img_pulse && dep_img, 5))
		else $error("pen_d5 does not follow the image frame strobe by 5 cycles");

endmodule

/* tb_clk.sv */
module tb_clk (
	output logic clk,
	output logic resetn
);

	timeunit 1ns;
	timeprecision 1ps;

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held low for the first 5 cycles
	initial begin
		resetn = 1'b0;
		repeat (5) @(posedge clk);
		resetn <= 1'b1;
	end

endmodule

/* pm_top.sv */
module pm_top (
	input  logic                                  clk,
	input  logic                                  resetn,
	input  logic                                  wr_en,
	input  pm_pkg::ch_t                           wr_ch,
	input  pm_pkg::pm_req_t                       wr_req,
	input  logic                                  go,
	input  pm_pkg::axis_mask_t                    go_mask,
	input  logic                                  img_pulse,
	input  pm_pkg::axis_mask_t                    img_valid,
	input  pm_pkg::px_t [pm_pkg::n_axis-1:0]      img_pos,
	output pm_pkg::step_t [pm_pkg::n_axis-1:0]    position,
	output pm_pkg::axis_mask_t                    done_mask,
	output pm_pkg::axis_mask_t                    over_mask,
	output logic                                  all_done
);

	pm_pkg::pm_req_t [pm_pkg::n_axis-1:0] act_req;
	pm_pkg::axis_mask_t arm;
	pm_pkg::axis_mask_t done;
	pm_pkg::axis_mask_t over;

	req_regs u_req (
		.clk     (clk),
		.resetn  (resetn),
		.wr_en   (wr_en),
		.wr_ch   (wr_ch),
		.wr_req  (wr_req),
		.go      (go),
		.go_mask (go_mask),
		.act_req (act_req),
		.arm     (arm)
	);

	// one channel per axis, camera strobe shared
	for (genvar i = 0; i < pm_pkg::n_axis; i++) begin : g_axis
		pm_channel u_ch (
			.clk       (clk),
			.resetn    (resetn),
			.arm       (arm[i]),
			.req       (act_req[i]),
			.img_pulse (img_pulse),
			.img_valid (img_valid[i]),
			.img_pos   (img_pos[i]),
			.position  (position[i]),
			.done      (done[i]),
			.over      (over[i])
		);
	end

	status_collect u_status (
		.clk       (clk),
		.resetn    (resetn),
		.arm       (arm),
		.done      (done),
		.over      (over),
		.done_mask (done_mask),
		.over_mask (over_mask),
		.all_done  (all_done)
	);

endmodule

/* status_collect.sv */
module status_collect (
	input  logic                clk,
	input  logic                resetn,
	input  pm_pkg::axis_mask_t  arm,
	input  pm_pkg::axis_mask_t  done,
	input  pm_pkg::axis_mask_t  over,
	output pm_pkg::axis_mask_t  done_mask,
	output pm_pkg::axis_mask_t  over_mask,
	output logic                all_done
);

	// every axis armed since reset
	pm_pkg::axis_mask_t armed;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			armed <= '0;
			done_mask <= '0;
			over_mask <= '0;
			all_done <= 1'b0;
		end else begin
			armed <= armed | arm;
			// freshly armed axes drop out right away
			done_mask <= done & ~arm;
			over_mask <= over & ~arm;
			all_done <= (arm == '0) && (armed != '0) && ((armed & ~done) == '0);
		end
	end

endmodule

/* pm_channel.sv */
module pm_channel (
	input  logic             clk,
	input  logic             resetn,
	input  logic             arm,
	input  pm_pkg::pm_req_t  req,
	input  logic             img_pulse,
	input  logic             img_valid,
	input  pm_pkg::px_t      img_pos,
	output pm_pkg::step_t    position,
	output logic             done,
	output logic             over
);

	pm_pkg::px_t rd_addr;
	pm_pkg::step_t rd_data;
	pm_pkg::step_t movie_pos;
	pm_pkg::motor_cmd_t m_cmd;
	logic m_start;
	logic running;

	// registered gain lookup, band gain times pixel error
	always_ff @(posedge clk) begin
		rd_data <= pm_pkg::gain_lut[rd_addr[pm_pkg::img_w-1 -: pm_pkg::lut_w]] *
			pm_pkg::step_t'(rd_addr);
	end

	pm_ctl u_ctl (
		.clk        (clk),
		.resetn     (resetn),
		.arm        (arm),
		.req        (req),
		.img_pulse  (img_pulse),
		.img_valid  (img_valid),
		.img_pos    (img_pos),
		.m_running  (running),
		.m_position (position),
		.movie_pos  (movie_pos),
		.rd_data    (rd_data),
		.rd_addr    (rd_addr),
		.m_start    (m_start),
		.m_cmd      (m_cmd),
		.done       (done),
		.over       (over)
	);

	img_delay_ctl u_delay (
		.clk       (clk),
		.resetn    (resetn),
		.eof       (img_pulse),
		.delay_frm (req.delay_frm),
		.cur_pos   (position),
		.movie_pos (movie_pos)
	);

	motor_gen u_motor (
		.clk      (clk),
		.resetn   (resetn),
		.start    (m_start),
		.cmd      (m_cmd),
		.running  (running),
		.position (position)
	);

endmodule

/* motor_gen.sv */
module motor_gen (
	input  logic                clk,
	input  logic                resetn,
	input  logic                start,
	input  pm_pkg::motor_cmd_t  cmd,
	output logic                running,
	output pm_pkg::step_t       position
);

	pm_pkg::step_t delta;
	pm_pkg::step_t remain;
	pm_pkg::speed_t tick;
	pm_pkg::speed_t speed_r;
	logic back;

	// absolute moves travel from wherever the motor is now
	always_comb begin
		if (cmd.abs)
			delta = cmd.step - position;
		else
			delta = cmd.step;
	end

	// speed and direction held for the whole move
	always_ff @(posedge clk) begin
		if (start) begin
			speed_r <= cmd.speed;
			back <= delta[pm_pkg::step_w-1];
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			running <= 1'b0;
			position <= '0;
			remain <= '0;
			tick <= '0;
		end else if (start) begin
			running <= 1'b1;
			remain <= delta[pm_pkg::step_w-1] ? -delta : delta;
			tick <= '0;
		end else if (running) begin
			if (remain == 0) begin
				running <= 1'b0;
			end else if (tick == speed_r) begin
				// one step every speed+1 cycles
				tick <= '0;
				remain <= remain - 1;
				position <= back ? position - 1 : position + 1;
			end else begin
				tick <= tick + 1'b1;
			end
		end
	end

endmodule

/* pm_ctl.sv */
module pm_ctl (
	input  logic                clk,
	input  logic                resetn,
	input  logic                arm,
	input  pm_pkg::pm_req_t     req,
	input  logic                img_pulse,
	input  logic                img_valid,
	input  pm_pkg::px_t         img_pos,
	input  logic                m_running,
	input  pm_pkg::step_t       m_position,
	input  pm_pkg::step_t       movie_pos,
	input  pm_pkg::step_t       rd_data,
	output pm_pkg::px_t         rd_addr,
	output logic                m_start,
	output pm_pkg::motor_cmd_t  m_cmd,
	output logic                done,
	output logic                over
);

	pm_pkg::px_t pos_l;
	pm_pkg::px_t pos_d;
	pm_pkg::px_t pos_r;
	pm_pkg::px_t pos_c;
	pm_pkg::px_t pos_dmc;
	pm_pkg::px_t pos_cmd;
	pm_pkg::step_t dst_pos;
	logic pen_d1;
	logic pen_d2;
	logic pen_d3;
	logic pen_d4;
	logic pen_d5;
	logic pos_lofl;
	logic pos_rofr;
	logic pos_lofd;
	logic pos_ok;
	logic need_back;
	logic ok_d4;
	logic nb_d4;
	logic ok_d5;
	logic pos_over;
	logic armed;
	logic started;
	logic in_win;
	logic run_seen;
	logic can_go;

	// stage enables, one per pipeline stage
	always_ff @(posedge clk) begin
		if (!resetn) begin
			pen_d1 <= 1'b0;
			pen_d2 <= 1'b0;
			pen_d3 <= 1'b0;
			pen_d4 <= 1'b0;
			pen_d5 <= 1'b0;
		end else begin
			pen_d1 <= img_pulse & req.dep_img;
			pen_d2 <= pen_d1;
			pen_d3 <= pen_d2;
			pen_d4 <= pen_d3;
			pen_d5 <= pen_d4;
		end
	end

	// datapath stages, only read under their enable
	always_ff @(posedge clk) begin
		// window and current pixel at the frame strobe
		if (img_pulse) begin
			pos_l <= req.img_dst - req.img_tol;
			pos_d <= req.img_dst;
			pos_r <= req.img_dst + req.img_tol;
			pos_c <= img_pos;
		end
		if (pen_d1) begin
			pos_lofl <= pos_c < pos_l;
			pos_rofr <= pos_c > pos_r;
			pos_lofd <= pos_c < pos_d;
			pos_dmc <= pos_d - pos_c;
			pos_cmd <= pos_c - pos_d;
		end
		// error magnitude goes out to the gain table
		if (pen_d2) begin
			pos_ok <= !pos_lofl && !pos_rofr;
			need_back <= pos_lofd != pm_pkg::l2r;
			if (pos_rofr)
				rd_addr <= pos_cmd;
			else if (pos_lofl)
				rd_addr <= pos_dmc;
			else
				rd_addr <= '0;
		end
		if (pen_d3) begin
			ok_d4 <= pos_ok;
			nb_d4 <= need_back;
		end
		// rd_data is valid here, target is relative to the frame's position
		if (pen_d4) begin
			ok_d5 <= ok_d4;
			pos_over <= !ok_d4 && (nb_d4 != req.step[pm_pkg::step_w-1]);
			dst_pos <= nb_d4 ? movie_pos - rd_data : movie_pos + rd_data;
		end
	end

	assign can_go = armed && !started && !over && !in_win;

	// start decision, at most one start per arm
	always_ff @(posedge clk) begin
		if (!resetn) begin
			armed <= 1'b0;
			started <= 1'b0;
			m_start <= 1'b0;
			over <= 1'b0;
			in_win <= 1'b0;
		end else if (arm) begin
			armed <= 1'b1;
			started <= 1'b0;
			m_start <= 1'b0;
			over <= 1'b0;
			in_win <= 1'b0;
		end else begin
			m_start <= 1'b0;
			if (can_go && !req.dep_img) begin
				m_start <= 1'b1;
				started <= 1'b1;
			end else if (can_go && pen_d5 && img_valid) begin
				if (ok_d5) begin
					in_win <= 1'b1;
				end else if (pos_over) begin
					over <= 1'b1;
				end else begin
					m_start <= 1'b1;
					started <= 1'b1;
				end
			end
		end
	end

	// command loaded alongside the start decision
	// image step is the signed table value once movie_pos has caught up
	always_ff @(posedge clk) begin
		if (!req.dep_img)
			m_cmd <= '{abs: req.abs, speed: req.speed, step: req.step};
		else if (pen_d5)
			m_cmd <= '{abs: 1'b0, speed: req.speed, step: dst_pos - m_position};
	end

	// done once the motor has run and stopped, or on over or in window
	always_ff @(posedge clk) begin
		if (!resetn) begin
			run_seen <= 1'b0;
			done <= 1'b0;
		end else if (arm) begin
			run_seen <= 1'b0;
			done <= 1'b0;
		end else begin
			if (started && m_running)
				run_seen <= 1'b1;
			if ((run_seen && !m_running) || over || in_win)
				done <= 1'b1;
		end
	end

endmodule

/* img_delay_ctl.sv */
module img_delay_ctl (
	input  logic           clk,
	input  logic           resetn,
	input  logic           eof,
	input  pm_pkg::frm_t   delay_frm,
	input  pm_pkg::step_t  cur_pos,
	output pm_pkg::step_t  movie_pos
);

	// position history, tap 0 is the latest frame
	pm_pkg::step_t taps [pm_pkg::n_tap];

	// motor position starts at zero, so does the history
	always_ff @(posedge clk) begin
		if (!resetn) begin
			taps <= '{default: '0};
		end else if (eof) begin
			taps[0] <= cur_pos;
			for (int i = 1; i < pm_pkg::n_tap; i++)
				taps[i] <= taps[i-1];
		end
	end

	// position at the frame the camera is reporting on
	assign movie_pos = taps[delay_frm];

endmodule

/* req_regs.sv */
module req_regs (
	input  logic                                   clk,
	input  logic                                   resetn,
	input  logic                                   wr_en,
	input  pm_pkg::ch_t                            wr_ch,
	input  pm_pkg::pm_req_t                        wr_req,
	input  logic                                   go,
	input  pm_pkg::axis_mask_t                     go_mask,
	output pm_pkg::pm_req_t [pm_pkg::n_axis-1:0]   act_req,
	output pm_pkg::axis_mask_t                     arm
);

	pm_pkg::pm_req_t [pm_pkg::n_axis-1:0] shadow;

	// host writes land in the shadow bank
	always_ff @(posedge clk) begin
		if (!resetn) begin
			shadow <= '0;
		end else if (wr_en) begin
			shadow[wr_ch] <= wr_req;
		end
	end

	// go copies masked shadows, arm follows one cycle later
	always_ff @(posedge clk) begin
		if (!resetn) begin
			act_req <= '0;
			arm <= '0;
		end else begin
			arm <= go ? go_mask : '0;
			if (go) begin
				for (int i = 0; i < pm_pkg::n_axis; i++) begin
					if (go_mask[i])
						act_req[i] <= shadow[i];
				end
			end
		end
	end

endmodule

/* pm_pkg.sv */
package pm_pkg;

	// axis count and datapath widths
	localparam int n_axis = 4;
	localparam int img_w = 12;
	localparam int step_w = 32;
	localparam int speed_w = 16;
	localparam int frm_w = 2;

	// host channel select and delay line depth
	localparam int ch_w = $clog2(n_axis);
	localparam int n_tap = 2 ** frm_w;

	// gain table indexed by the top bits of pixel error
	localparam int lut_w = 3;

	// pixel to motor direction sense
	localparam logic l2r = 1'b1;

	typedef logic [img_w-1:0] px_t;
	typedef logic signed [step_w-1:0] step_t;
	typedef logic [speed_w-1:0] speed_t;
	typedef logic [frm_w-1:0] frm_t;
	typedef logic [n_axis-1:0] axis_mask_t;
	typedef logic [ch_w-1:0] ch_t;

	// one motion request, sign of step is the allowed direction
	typedef struct packed {
		logic dep_img;
		logic abs;
		px_t img_dst;
		px_t img_tol;
		speed_t speed;
		step_t step;
		frm_t delay_frm;
	} pm_req_t;

	typedef struct packed {
		logic abs;
		speed_t speed;
		step_t step;
	} motor_cmd_t;

	// steps per pixel, one entry per error band
	localparam step_t gain_lut [2 ** lut_w] = '{1, 1, 2, 2, 3, 3, 4, 4};

endpackage
